// ==== ooo_issue_pkg.sv ====
`default_nettype none

package ooo_issue_pkg;

    localparam int DATA_WIDTH = 16;  // one word
    localparam int TAG_WIDTH  = 5;   // 32 physical tags
    localparam int RS_SIZE    = 8;
    localparam int MULT_STEPS = DATA_WIDTH;  // one shift-add step per multiplier bit

    // occupancy counter has to hold RS_SIZE itself
    localparam int RS_CNT_WIDTH   = $clog2(RS_SIZE + 1);
    localparam int STEP_CNT_WIDTH = $clog2(MULT_STEPS);

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_code_t;

    // unit class of an op, only the multiply goes to the multiplier
    function automatic logic is_mult_op(input op_code_t op);
        return op == OP_MUL;
    endfunction

endpackage

`default_nettype wire

// ==== issue_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_select #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    // taken[i] is set once some lower index has requested
    logic [WIDTH:0] taken;

    always_comb begin
        taken[0] = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            grant[i]     = request[i] && !taken[i];
            taken[i + 1] = taken[i] || request[i];
        end
    end

    assign any_grant = taken[WIDTH];  // any request wins somewhere

    // grant has to be the lowest set request bit, or nothing
    always_comb begin
        assert final ((grant == (request & (~request + 1'b1))) && (any_grant == (|request)))
            else $error("issue_select: grant is not the lowest request");
    end

endmodule

`default_nettype wire

// ==== rs_station.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_station import ooo_issue_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  op_code_t              dispatch_op,
    input  logic [TAG_WIDTH-1:0]  dispatch_dest_tag,
    input  logic                  dispatch_src1_ready,
    input  logic [DATA_WIDTH-1:0] dispatch_src1,
    input  logic                  dispatch_src2_ready,
    input  logic [DATA_WIDTH-1:0] dispatch_src2,
    input  logic                  alu_cdb_valid,
    input  logic [TAG_WIDTH-1:0]  alu_cdb_tag,
    input  logic [DATA_WIDTH-1:0] alu_cdb_value,
    input  logic                  mult_cdb_valid,
    input  logic [TAG_WIDTH-1:0]  mult_cdb_tag,
    input  logic [DATA_WIDTH-1:0] mult_cdb_value,
    input  logic                  mult_busy,
    output logic                  rs_full,
    output logic                  alu_issue,
    output op_code_t              alu_op,
    output logic [DATA_WIDTH-1:0] alu_operand1,
    output logic [DATA_WIDTH-1:0] alu_operand2,
    output logic [TAG_WIDTH-1:0]  alu_dest_tag,
    output logic                  mult_issue,
    output logic [DATA_WIDTH-1:0] mult_operand1,
    output logic [DATA_WIDTH-1:0] mult_operand2,
    output logic [TAG_WIDTH-1:0]  mult_dest_tag
);

    logic [RS_SIZE-1:0]      entry_valid;
    op_code_t                entry_op [RS_SIZE];
    logic [TAG_WIDTH-1:0]    entry_dest [RS_SIZE];
    logic [RS_SIZE-1:0]      entry_src1_ready;
    logic [DATA_WIDTH-1:0]   entry_src1 [RS_SIZE];  // value once ready, tag before
    logic [RS_SIZE-1:0]      entry_src2_ready;
    logic [DATA_WIDTH-1:0]   entry_src2 [RS_SIZE];
    logic [RS_CNT_WIDTH-1:0] occupancy;

    logic [RS_SIZE-1:0] entry_ready;
    logic [RS_SIZE-1:0] free_slot;
    logic [RS_SIZE-1:0] alu_request;
    logic [RS_SIZE-1:0] mult_request;
    logic [RS_SIZE-1:0] alu_grant;
    logic [RS_SIZE-1:0] mult_grant;
    logic               dispatch_write;

    // snoop both result buses for a pending source, returns {ready, field}
    function automatic logic [DATA_WIDTH:0] resolve(input logic ready,
                                                    input logic [DATA_WIDTH-1:0] field);
        logic [DATA_WIDTH:0] result;
        result = {ready, field};
        if (!ready && alu_cdb_valid && alu_cdb_tag == field[TAG_WIDTH-1:0]) begin
            result = {1'b1, alu_cdb_value};
        end else if (!ready && mult_cdb_valid && mult_cdb_tag == field[TAG_WIDTH-1:0]) begin
            result = {1'b1, mult_cdb_value};
        end
        return result;
    endfunction

    assign rs_full        = (occupancy == RS_CNT_WIDTH'(RS_SIZE));
    assign dispatch_write = dispatch_valid && !rs_full;
    assign entry_ready    = entry_valid & entry_src1_ready & entry_src2_ready;

    // lowest free entry, the downward scan leaves the lowest index standing
    always_comb begin
        free_slot = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_slot    = '0;
                free_slot[i] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            alu_request[i]  = entry_ready[i] && !is_mult_op(entry_op[i]);
            mult_request[i] = entry_ready[i] && is_mult_op(entry_op[i]) && !mult_busy;
        end
    end

    issue_select #(.WIDTH(RS_SIZE)) u_alu_select (
        .request   (alu_request),
        .grant     (alu_grant),
        .any_grant (alu_issue)
    );

    issue_select #(.WIDTH(RS_SIZE)) u_mult_select (
        .request   (mult_request),
        .grant     (mult_grant),
        .any_grant (mult_issue)
    );

    // grants are one-hot so an or-style mux is enough
    always_comb begin
        alu_op        = OP_ADD;
        alu_operand1  = '0;
        alu_operand2  = '0;
        alu_dest_tag  = '0;
        mult_operand1 = '0;
        mult_operand2 = '0;
        mult_dest_tag = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (alu_grant[i]) begin
                alu_op       = entry_op[i];
                alu_operand1 = entry_src1[i];
                alu_operand2 = entry_src2[i];
                alu_dest_tag = entry_dest[i];
            end
            if (mult_grant[i]) begin
                mult_operand1 = entry_src1[i];
                mult_operand2 = entry_src2[i];
                mult_dest_tag = entry_dest[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            occupancy   <= '0;
        end else begin
            entry_valid <= (entry_valid & ~alu_grant & ~mult_grant)
                         | (dispatch_write ? free_slot : '0);
            occupancy   <= occupancy + RS_CNT_WIDTH'(dispatch_write)
                         - RS_CNT_WIDTH'(alu_issue) - RS_CNT_WIDTH'(mult_issue);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (dispatch_write && free_slot[i]) begin
                entry_op[i]   <= dispatch_op;
                entry_dest[i] <= dispatch_dest_tag;
                // same-cycle broadcast is caught on the way in
                {entry_src1_ready[i], entry_src1[i]} <= resolve(dispatch_src1_ready, dispatch_src1);
                {entry_src2_ready[i], entry_src2[i]} <= resolve(dispatch_src2_ready, dispatch_src2);
            end else begin
                {entry_src1_ready[i], entry_src1[i]} <= resolve(entry_src1_ready[i], entry_src1[i]);
                {entry_src2_ready[i], entry_src2[i]} <= resolve(entry_src2_ready[i], entry_src2[i]);
            end
        end
    end

    // dispatcher has to respect rs_full
    assert property (@(posedge clock) disable iff (reset) dispatch_valid |-> !rs_full)
        else $error("rs_station: dispatch while full");

    assert property (@(posedge clock) disable iff (reset)
        occupancy == RS_CNT_WIDTH'($countones(entry_valid)))
        else $error("rs_station: occupancy out of step with valid entries");

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit import ooo_issue_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue,
    input  op_code_t              op,
    input  logic [DATA_WIDTH-1:0] operand1,
    input  logic [DATA_WIDTH-1:0] operand2,
    input  logic [TAG_WIDTH-1:0]  dest_tag,
    output logic                  cdb_valid,
    output logic [TAG_WIDTH-1:0]  cdb_tag,
    output logic [DATA_WIDTH-1:0] cdb_value
);

    logic [DATA_WIDTH-1:0] result;

    always_comb begin
        case (op)
            OP_ADD:  result = operand1 + operand2;
            OP_SUB:  result = operand1 - operand2;  // wraps modulo 2^DATA_WIDTH
            OP_AND:  result = operand1 & operand2;
            OP_XOR:  result = operand1 ^ operand2;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue;  // one-cycle strobe
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            cdb_tag   <= dest_tag;
            cdb_value <= result;
        end
    end

    // station must steer multiplies elsewhere
    assert property (@(posedge clock) disable iff (reset) issue |-> !is_mult_op(op))
        else $error("alu_unit: multiply issued to ALU");

endmodule

`default_nettype wire

// ==== mult_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module mult_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic issue,
    input  logic step_done,
    output logic timer_start,
    output logic step_enable,
    output logic broadcast,
    output logic busy
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        STEP = 2'd1,
        DONE = 2'd2
    } mult_state_t;

    mult_state_t state;
    mult_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (issue) state_next = STEP;
            STEP:    if (step_done) state_next = DONE;  // last step lands at this edge
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign timer_start = issue && (state == IDLE);
    assign step_enable = (state == STEP);
    assign broadcast   = (state == DONE);
    assign busy        = (state != IDLE);  // held through the broadcast cycle

    assert property (@(posedge clock) disable iff (reset) issue |-> !busy)
        else $error("mult_ctrl: issue while multiplier busy");

endmodule

`default_nettype wire

// ==== mult_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mult_timer import ooo_issue_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic enable,
    output logic step_done
);

    logic [STEP_CNT_WIDTH-1:0] steps_left;

    always_ff @(posedge clock) begin
        if (reset) begin
            steps_left <= '0;
        end else if (start) begin
            steps_left <= STEP_CNT_WIDTH'(MULT_STEPS - 1);
        end else if (enable && steps_left != '0) begin
            steps_left <= steps_left - 1'b1;
        end
    end

    assign step_done = (steps_left == '0);  // final step is under way

endmodule

`default_nettype wire

// ==== mult_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module mult_datapath import ooo_issue_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load,
    input  logic                  step,
    input  logic                  broadcast,
    input  logic [DATA_WIDTH-1:0] operand1,
    input  logic [DATA_WIDTH-1:0] operand2,
    input  logic [TAG_WIDTH-1:0]  dest_tag,
    output logic                  cdb_valid,
    output logic [TAG_WIDTH-1:0]  cdb_tag,
    output logic [DATA_WIDTH-1:0] cdb_value
);

    logic [DATA_WIDTH-1:0] multiplicand;  // shifts left each step
    logic [DATA_WIDTH-1:0] multiplier;    // shifts right, low bit picks the add
    logic [DATA_WIDTH-1:0] product;
    logic [TAG_WIDTH-1:0]  tag;

    always_ff @(posedge clock) begin
        if (load) begin
            multiplicand <= operand1;
            multiplier   <= operand2;
            product      <= '0;
            tag          <= dest_tag;
        end else if (step) begin
            if (multiplier[0]) begin
                product <= product + multiplicand;  // upper bits drop off
            end
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    assign cdb_valid = broadcast;
    assign cdb_tag   = tag;
    assign cdb_value = product;

    // a new multiply only loads once the previous one has drained
    assert property (@(posedge clock) disable iff (reset) !(load && (step || broadcast)))
        else $error("mult_datapath: load during an active multiply");

endmodule

`default_nettype wire

// ==== ooo_issue_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_issue_top import ooo_issue_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  op_code_t              dispatch_op,
    input  logic [TAG_WIDTH-1:0]  dispatch_dest_tag,
    input  logic                  dispatch_src1_ready,
    input  logic [DATA_WIDTH-1:0] dispatch_src1,
    input  logic                  dispatch_src2_ready,
    input  logic [DATA_WIDTH-1:0] dispatch_src2,
    output logic                  rs_full,
    output logic                  alu_cdb_valid,
    output logic [TAG_WIDTH-1:0]  alu_cdb_tag,
    output logic [DATA_WIDTH-1:0] alu_cdb_value,
    output logic                  mult_cdb_valid,
    output logic [TAG_WIDTH-1:0]  mult_cdb_tag,
    output logic [DATA_WIDTH-1:0] mult_cdb_value
);

    logic                  alu_issue;
    op_code_t              alu_op;
    logic [DATA_WIDTH-1:0] alu_operand1;
    logic [DATA_WIDTH-1:0] alu_operand2;
    logic [TAG_WIDTH-1:0]  alu_dest_tag;
    logic                  mult_issue;
    logic [DATA_WIDTH-1:0] mult_operand1;
    logic [DATA_WIDTH-1:0] mult_operand2;
    logic [TAG_WIDTH-1:0]  mult_dest_tag;
    logic                  mult_busy;
    logic                  timer_start;
    logic                  step_enable;
    logic                  step_done;
    logic                  mult_broadcast;

    rs_station u_rs_station (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_dest_tag   (dispatch_dest_tag),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src2_ready (dispatch_src2_ready),
        .dispatch_src2       (dispatch_src2),
        .alu_cdb_valid       (alu_cdb_valid),   // buses loop back for wakeup
        .alu_cdb_tag         (alu_cdb_tag),
        .alu_cdb_value       (alu_cdb_value),
        .mult_cdb_valid      (mult_cdb_valid),
        .mult_cdb_tag        (mult_cdb_tag),
        .mult_cdb_value      (mult_cdb_value),
        .mult_busy           (mult_busy),
        .rs_full             (rs_full),
        .alu_issue           (alu_issue),
        .alu_op              (alu_op),
        .alu_operand1        (alu_operand1),
        .alu_operand2        (alu_operand2),
        .alu_dest_tag        (alu_dest_tag),
        .mult_issue          (mult_issue),
        .mult_operand1       (mult_operand1),
        .mult_operand2       (mult_operand2),
        .mult_dest_tag       (mult_dest_tag)
    );

    alu_unit u_alu_unit (
        .clock     (clock),
        .reset     (reset),
        .issue     (alu_issue),
        .op        (alu_op),
        .operand1  (alu_operand1),
        .operand2  (alu_operand2),
        .dest_tag  (alu_dest_tag),
        .cdb_valid (alu_cdb_valid),
        .cdb_tag   (alu_cdb_tag),
        .cdb_value (alu_cdb_value)
    );

    mult_ctrl u_mult_ctrl (
        .clock       (clock),
        .reset       (reset),
        .issue       (mult_issue),
        .step_done   (step_done),
        .timer_start (timer_start),
        .step_enable (step_enable),
        .broadcast   (mult_broadcast),
        .busy        (mult_busy)
    );

    mult_timer u_mult_timer (
        .clock     (clock),
        .reset     (reset),
        .start     (timer_start),
        .enable    (step_enable),
        .step_done (step_done)
    );

    mult_datapath u_mult_datapath (
        .clock     (clock),
        .reset     (reset),
        .load      (mult_issue),  // operands captured at the issue edge
        .step      (step_enable),
        .broadcast (mult_broadcast),
        .operand1  (mult_operand1),
        .operand2  (mult_operand2),
        .dest_tag  (mult_dest_tag),
        .cdb_valid (mult_cdb_valid),
        .cdb_tag   (mult_cdb_tag),
        .cdb_value (mult_cdb_value)
    );

endmodule

`default_nettype wire

// ==== tb_ooo_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_issue import ooo_issue_pkg::*; ();

    localparam int N_INDEP  = 40;
    localparam int N_CHAIN  = 30;
    localparam int N_SAME   = 4;
    localparam int N_MIX    = 30;
    localparam int ALU_COST = 4;               // worst cycles per ALU op
    localparam int MUL_COST = MULT_STEPS + 4;  // issue, steps, broadcast, slack
    localparam int CYCLE_LIMIT = 2 * (40 + (N_INDEP + N_CHAIN + 2 * N_SAME) * ALU_COST
                                     + (N_MIX + 2) * MUL_COST + (RS_SIZE + 1) * MUL_COST);
    localparam int NUM_TAGS = 1 << TAG_WIDTH;

    logic                  clock;
    logic                  reset;
    logic                  dispatch_valid;
    op_code_t              dispatch_op;
    logic [TAG_WIDTH-1:0]  dispatch_dest_tag;
    logic                  dispatch_src1_ready;
    logic [DATA_WIDTH-1:0] dispatch_src1;
    logic                  dispatch_src2_ready;
    logic [DATA_WIDTH-1:0] dispatch_src2;
    logic                  rs_full;
    logic                  alu_cdb_valid;
    logic [TAG_WIDTH-1:0]  alu_cdb_tag;
    logic [DATA_WIDTH-1:0] alu_cdb_value;
    logic                  mult_cdb_valid;
    logic [TAG_WIDTH-1:0]  mult_cdb_tag;
    logic [DATA_WIDTH-1:0] mult_cdb_value;

    // scoreboard indexed by tag
    logic                  in_flight [NUM_TAGS];
    logic [DATA_WIDTH-1:0] exp_val [NUM_TAGS];
    op_code_t              tag_op [NUM_TAGS];
    logic [TAG_WIDTH-1:0]  free_tags [$];

    logic [31:0] rng_state = 32'd74;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          dispatched = 0;
    int          completed = 0;
    int          mult_pending = 0;     // multiplies dispatched, not yet broadcast
    int          alu_during_mult = 0;
    logic        mult_returned = 1'b0;  // first multiply of the test is back
    int          test_checks;
    int          test_errors;
    string       test_name = "reset";

    ooo_issue_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] rand_word();
        return DATA_WIDTH'(next_rand());
    endfunction

    function automatic op_code_t rand_alu_op();
        return op_code_t'(3'(next_rand() % 4));  // add, sub, and, xor
    endfunction

    // expected result, kept modulo 2^DATA_WIDTH
    function automatic logic [DATA_WIDTH-1:0] ref_result(input op_code_t op,
                                                         input logic [DATA_WIDTH-1:0] a,
                                                         input logic [DATA_WIDTH-1:0] b);
        logic [2*DATA_WIDTH-1:0] wide;
        case (op)
            OP_ADD:  wide = a + b;
            OP_SUB:  wide = a - b;
            OP_AND:  wide = a & b;
            OP_XOR:  wide = a ^ b;
            OP_MUL:  wide = a * b;
            default: wide = '0;
        endcase
        return wide[DATA_WIDTH-1:0];
    endfunction

    task automatic check_broadcast(input logic [TAG_WIDTH-1:0] tag,
                                   input logic [DATA_WIDTH-1:0] value, input logic from_mult);
        checks++;
        assert (in_flight[tag]) else begin
            $display("%s: tag %0d broadcast with no instruction pending on it", test_name, tag);
            errors++;
        end
        if (in_flight[tag]) begin
            assert (is_mult_op(tag_op[tag]) == from_mult) else begin
                $display("%s: tag %0d came back on the wrong result bus", test_name, tag);
                errors++;
            end
            assert (value == exp_val[tag]) else begin
                $display("ERR %s tag %0d expected %h actual %h", test_name, tag,
                         exp_val[tag], value);
                errors++;
            end
            in_flight[tag] = 1'b0;
            free_tags.push_back(tag);  // tag free for reuse only now
            completed++;
            if (from_mult) begin
                mult_pending--;
                mult_returned = 1'b1;
            end else if (mult_pending > 0 && !mult_returned) begin
                alu_during_mult++;  // multiplier still on its first multiply
            end
        end
    endtask

    // buses hold still from one edge to the next, read them at the rising edge
    always @(posedge clock) begin
        if (!reset) begin
            if (alu_cdb_valid) begin
                check_broadcast(alu_cdb_tag, alu_cdb_value, 1'b0);
            end
            if (mult_cdb_valid) begin
                check_broadcast(mult_cdb_tag, mult_cdb_value, 1'b1);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, results stopped arriving", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // drives one dispatch at the current falling edge
    task automatic drive_dispatch(input op_code_t op, input logic s1_tag,
                                  input logic [DATA_WIDTH-1:0] s1, input logic s2_tag,
                                  input logic [DATA_WIDTH-1:0] s2,
                                  output logic [TAG_WIDTH-1:0] dest);
        logic [DATA_WIDTH-1:0] v1;
        logic [DATA_WIDTH-1:0] v2;
        while (rs_full) begin
            dispatch_valid = 1'b0;
            @(negedge clock);
        end
        v1 = s1_tag ? exp_val[s1[TAG_WIDTH-1:0]] : s1;
        v2 = s2_tag ? exp_val[s2[TAG_WIDTH-1:0]] : s2;
        // a source that broadcast during the wait goes in as a value
        s1_tag = s1_tag && in_flight[s1[TAG_WIDTH-1:0]];
        s2_tag = s2_tag && in_flight[s2[TAG_WIDTH-1:0]];
        dest = free_tags.pop_front();
        in_flight[dest] = 1'b1;
        exp_val[dest] = ref_result(op, v1, v2);
        tag_op[dest] = op;
        dispatched++;
        if (is_mult_op(op)) begin
            mult_pending++;
        end
        dispatch_valid      = 1'b1;
        dispatch_op         = op;
        dispatch_dest_tag   = dest;
        dispatch_src1_ready = !s1_tag;
        dispatch_src1       = s1_tag ? DATA_WIDTH'(s1[TAG_WIDTH-1:0]) : v1;
        dispatch_src2_ready = !s2_tag;
        dispatch_src2       = s2_tag ? DATA_WIDTH'(s2[TAG_WIDTH-1:0]) : v2;
    endtask

    task automatic dispatch_next(input op_code_t op, input logic s1_tag,
                                 input logic [DATA_WIDTH-1:0] s1, input logic s2_tag,
                                 input logic [DATA_WIDTH-1:0] s2,
                                 output logic [TAG_WIDTH-1:0] dest);
        @(negedge clock);
        drive_dispatch(op, s1_tag, s1, s2_tag, s2, dest);
    endtask

    task automatic go_idle();
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        while (completed != dispatched) begin
            @(negedge clock);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("%-12s %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    initial begin
        logic [TAG_WIDTH-1:0]  tag;
        logic [TAG_WIDTH-1:0]  last_tag;
        logic [TAG_WIDTH-1:0]  prev_tag;
        logic [TAG_WIDTH-1:0]  mul_tag;
        logic [DATA_WIDTH-1:0] src2;
        logic                  use_tag;
        op_code_t              op;
        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_op         = OP_ADD;
        dispatch_dest_tag   = '0;
        dispatch_src1_ready = 1'b1;
        dispatch_src1       = '0;
        dispatch_src2_ready = 1'b1;
        dispatch_src2       = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            in_flight[t] = 1'b0;
            free_tags.push_back(TAG_WIDTH'(t));
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        begin_test("reset");
        checks++;
        assert ({rs_full, alu_cdb_valid, mult_cdb_valid} == 3'b000) else begin
            $display("ERR %s expected %b actual %b", test_name, 3'b000,
                     {rs_full, alu_cdb_valid, mult_cdb_valid});
            errors++;
        end
        end_test();

        begin_test("independent");
        for (int i = 0; i < N_INDEP; i++) begin
            dispatch_next(rand_alu_op(), 1'b0, rand_word(), 1'b0, rand_word(), tag);
        end
        go_idle();
        drain();
        end_test();

        begin_test("chains");
        dispatch_next(OP_ADD, 1'b0, rand_word(), 1'b0, rand_word(), last_tag);
        prev_tag = last_tag;
        for (int i = 0; i < N_CHAIN; i++) begin
            use_tag  = (next_rand() % 2) == 0;
            src2     = use_tag ? DATA_WIDTH'(prev_tag) : rand_word();
            prev_tag = last_tag;
            dispatch_next(rand_alu_op(), 1'b1, DATA_WIDTH'(prev_tag), use_tag, src2, last_tag);
        end
        go_idle();
        drain();
        // consumer lands in the very cycle its producer is on the bus
        for (int i = 0; i < N_SAME; i++) begin
            dispatch_next(rand_alu_op(), 1'b0, rand_word(), 1'b0, rand_word(), tag);
            go_idle();
            while (!(alu_cdb_valid && alu_cdb_tag == tag)) begin
                @(negedge clock);
            end
            drive_dispatch(rand_alu_op(), 1'b1, DATA_WIDTH'(tag), 1'b0, rand_word(), last_tag);
            go_idle();
        end
        drain();
        end_test();

        begin_test("mixed");
        alu_during_mult = 0;
        mult_returned   = 1'b0;
        dispatch_next(OP_MUL, 1'b0, rand_word(), 1'b0, rand_word(), tag);  // back to back
        dispatch_next(OP_MUL, 1'b0, rand_word(), 1'b0, rand_word(), tag);
        for (int i = 0; i < N_MIX; i++) begin
            op = ((next_rand() % 3) == 0) ? OP_MUL : rand_alu_op();
            dispatch_next(op, 1'b0, rand_word(), 1'b0, rand_word(), tag);
        end
        go_idle();
        drain();
        checks++;
        assert (alu_during_mult > 0) else begin
            $display("%s: no ALU result completed while the first multiply was running",
                     test_name);
            errors++;
        end
        end_test();

        begin_test("fill");
        dispatch_next(OP_MUL, 1'b0, rand_word(), 1'b0, rand_word(), mul_tag);
        for (int i = 0; i < RS_SIZE; i++) begin
            dispatch_next(rand_alu_op(), 1'b1, DATA_WIDTH'(mul_tag), 1'b0, rand_word(), tag);
        end
        go_idle();
        checks++;
        assert (rs_full && in_flight[mul_tag]) else begin
            $display("%s: station was not full before the multiply broadcast", test_name);
            errors++;
        end
        drain();
        end_test();

        begin_test("completion");
        repeat (20) @(negedge clock);  // quiet window, stray broadcasts show up in the checker
        checks++;
        assert (dispatched == completed && free_tags.size() == NUM_TAGS) else begin
            $display("%s: %0d dispatched, %0d completed, %0d tags free", test_name,
                     dispatched, completed, free_tags.size());
            errors++;
        end
        end_test();

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ooo_issue.f ====
ooo_issue_pkg.sv
issue_select.sv
rs_station.sv
alu_unit.sv
mult_ctrl.sv
mult_timer.sv
mult_datapath.sv
ooo_issue_top.sv
tb_ooo_issue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ooo_issue
FILELIST  ?= ooo_issue.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
